/* source/ninjin_pkg.sv */
package ninjin_pkg;

  // ====================
  // host side widths
  // ====================
  typedef logic [31:0] word_t;

  // 64 register ports
  typedef logic [5:0] reg_addr_t;

  // half-word count field
  localparam int LWIDTH = 16;

  // ====================
  // register map
  // ====================
  // any write starts a job
  localparam reg_addr_t REG_REQ        = 6'd1;
  localparam reg_addr_t REG_QBITS      = 6'd2;
  localparam reg_addr_t REG_IN_OFFSET  = 6'd3;
  localparam reg_addr_t REG_OUT_OFFSET = 6'd4;
  localparam reg_addr_t REG_NET_OFFSET = 6'd5;

  // total_out upper half, total_in lower half
  localparam reg_addr_t REG_BASE       = 6'd10;

  // bit 31 is bias_en
  localparam reg_addr_t REG_BIAS       = 6'd15;

  // bit 31 is relu_en
  localparam reg_addr_t REG_ACTV       = 6'd16;

  // bit 0 is ack
  localparam reg_addr_t REG_STATUS     = 6'd62;

endpackage

/* source/gobou_pkg.sv */
package gobou_pkg;

  // ====================
  // datapath widths
  // ====================
  localparam int DWIDTH = 16;

  typedef logic signed [DWIDTH-1:0]   data_t;
  // product or running sum
  typedef logic signed [2*DWIDTH-1:0] acc_t;

  // fraction shift
  typedef logic [3:0]  qbits_t;

  typedef logic [11:0] img_addr_t;
  typedef logic [11:0] net_addr_t;
  typedef logic [15:0] count_t;

  // ====================
  // layer sequencer
  // ====================
  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_DRAIN,
    S_WRITE
  } ctrl_state_t;

endpackage

/* source/ninjin_regs.sv */
`timescale 1ns/1ps

module ninjin_regs (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  reg_we,
  input  logic                  reg_re,
  input  ninjin_pkg::reg_addr_t reg_addr,
  input  ninjin_pkg::word_t     reg_wdata,
  input  logic                  done,
  output ninjin_pkg::word_t     reg_rdata,
  output logic                  reg_rvalid,
  output logic                  start,
  output logic                  ack,
  output gobou_pkg::qbits_t     qbits,
  output gobou_pkg::img_addr_t  in_offset,
  output gobou_pkg::img_addr_t  out_offset,
  output gobou_pkg::net_addr_t  net_offset,
  output gobou_pkg::count_t     total_out,
  output gobou_pkg::count_t     total_in,
  output logic                  bias_en,
  output logic                  relu_en
);
  import ninjin_pkg::*;
  import gobou_pkg::*;

  // raw words as written by the host
  word_t req_word;
  word_t qbits_word;
  word_t in_off_word;
  word_t out_off_word;
  word_t net_off_word;
  word_t base_word;
  word_t bias_word;
  word_t actv_word;

  // ====================
  // host writes
  // ====================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_word     <= '0;
      qbits_word   <= '0;
      in_off_word  <= '0;
      out_off_word <= '0;
      net_off_word <= '0;
      base_word    <= '0;
      bias_word    <= '0;
      actv_word    <= '0;
      start        <= 1'b0;
    end else begin
      start <= reg_we && (reg_addr == REG_REQ);
      if (reg_we) begin
        case (reg_addr)
          REG_REQ:        req_word     <= reg_wdata;
          REG_QBITS:      qbits_word   <= reg_wdata;
          REG_IN_OFFSET:  in_off_word  <= reg_wdata;
          REG_OUT_OFFSET: out_off_word <= reg_wdata;
          REG_NET_OFFSET: net_off_word <= reg_wdata;
          REG_BASE:       base_word    <= reg_wdata;
          REG_BIAS:       bias_word    <= reg_wdata;
          REG_ACTV:       actv_word    <= reg_wdata;
          default: ;
        endcase
      end
    end
  end

  // job status, low while a job runs
  always_ff @(posedge clk) begin
    if (!xrst)
      ack <= 1'b0;
    else if (start)
      ack <= 1'b0;
    else if (done)
      ack <= 1'b1;
  end

  // ====================
  // readback
  // ====================
  always_ff @(posedge clk) begin
    if (!xrst)
      reg_rvalid <= 1'b0;
    else
      reg_rvalid <= reg_re;
  end

  always_ff @(posedge clk) begin
    if (reg_re) begin
      case (reg_addr)
        REG_REQ:        reg_rdata <= req_word;
        REG_QBITS:      reg_rdata <= qbits_word;
        REG_IN_OFFSET:  reg_rdata <= in_off_word;
        REG_OUT_OFFSET: reg_rdata <= out_off_word;
        REG_NET_OFFSET: reg_rdata <= net_off_word;
        REG_BASE:       reg_rdata <= base_word;
        REG_BIAS:       reg_rdata <= bias_word;
        REG_ACTV:       reg_rdata <= actv_word;
        REG_STATUS:     reg_rdata <= word_t'(ack);
        default:        reg_rdata <= '0;
      endcase
    end
  end

  // field unpacking
  assign qbits      = qbits_word[$bits(qbits_t)-1:0];
  assign in_offset  = in_off_word[$bits(img_addr_t)-1:0];
  assign out_offset = out_off_word[$bits(img_addr_t)-1:0];
  assign net_offset = net_off_word[$bits(net_addr_t)-1:0];
  assign total_out  = base_word[2*LWIDTH-1:LWIDTH];
  assign total_in   = base_word[LWIDTH-1:0];
  assign bias_en    = bias_word[$bits(word_t)-1];
  assign relu_en    = actv_word[$bits(word_t)-1];

endmodule

/* source/image_buffer.sv */
`timescale 1ns/1ps

module image_buffer #(
  parameter int IMG_DEPTH = 4096
) (
  input  logic                 clk,
  input  logic                 xrst,
  input  logic                 host_we,
  input  logic                 host_re,
  input  gobou_pkg::img_addr_t host_addr,
  input  gobou_pkg::data_t     host_wdata,
  input  logic                 eng_own,
  input  logic                 eng_we,
  input  gobou_pkg::img_addr_t eng_addr,
  input  gobou_pkg::data_t     eng_wdata,
  output gobou_pkg::data_t     rdata,
  output logic                 host_rvalid
);
  import gobou_pkg::*;

  data_t     mem [IMG_DEPTH];
  img_addr_t addr;
  data_t     wdata;
  logic      we;

  // engine owns the port while a job runs
  assign addr  = eng_own ? eng_addr  : host_addr;
  assign wdata = eng_own ? eng_wdata : host_wdata;
  assign we    = eng_own ? eng_we    : host_we;

  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];
  end

  always_ff @(posedge clk) begin
    if (!xrst)
      host_rvalid <= 1'b0;
    else
      host_rvalid <= host_re && !eng_own;
  end

  // host must wait for ack before touching the image
  assert property (@(posedge clk) disable iff (!xrst) eng_own |-> !(host_we || host_re))
    else $error("image_buffer: host access while engine owns the port");

endmodule

/* source/weight_buffer.sv */
`timescale 1ns/1ps

module weight_buffer #(
  parameter int NET_DEPTH = 4096
) (
  input  logic                 clk,
  input  logic                 net_we,
  input  gobou_pkg::net_addr_t net_addr,
  input  gobou_pkg::data_t     net_wdata,
  input  gobou_pkg::net_addr_t raddr,
  output gobou_pkg::data_t     rdata
);
  import gobou_pkg::*;

  // weights and biases, one neuron block after another
  data_t mem [NET_DEPTH];

  // host load side
  always_ff @(posedge clk) begin
    if (net_we)
      mem[net_addr] <= net_wdata;
  end

  // engine read side
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* source/gobou_ctrl.sv */
`timescale 1ns/1ps

module gobou_ctrl (
  input  logic                 clk,
  input  logic                 xrst,
  input  logic                 start,
  input  gobou_pkg::img_addr_t in_offset,
  input  gobou_pkg::img_addr_t out_offset,
  input  gobou_pkg::net_addr_t net_offset,
  input  gobou_pkg::count_t    total_out,
  input  gobou_pkg::count_t    total_in,
  input  logic                 bias_en,
  output logic                 busy,
  output logic                 done,
  output gobou_pkg::img_addr_t eng_addr,
  output logic                 eng_we,
  output gobou_pkg::net_addr_t net_raddr,
  output logic                 acc_en,
  output logic                 acc_first,
  output logic                 acc_bias
);
  import gobou_pkg::*;

  ctrl_state_t state;
  count_t      neuron;
  count_t      item;
  count_t      last_item;
  img_addr_t   in_ptr;
  net_addr_t   net_ptr;
  logic        drain_cnt;

  // bias adds one item per neuron
  assign last_item = total_in + count_t'(bias_en) - 16'd1;

  assign busy      = state != S_IDLE;
  assign acc_en    = state == S_READ;
  assign acc_first = acc_en && (item == '0);
  assign acc_bias  = acc_en && (item >= total_in);
  assign eng_we    = state == S_WRITE;
  assign eng_addr  = eng_we ? out_offset + img_addr_t'(neuron) : in_ptr;
  assign net_raddr = net_ptr;

  // ====================
  // sequencer
  // ====================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= S_IDLE;
      done      <= 1'b0;
      neuron    <= '0;
      item      <= '0;
      in_ptr    <= '0;
      net_ptr   <= '0;
      drain_cnt <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            neuron  <= '0;
            item    <= '0;
            in_ptr  <= in_offset;
            net_ptr <= net_offset;
            if (total_out == '0)
              done <= 1'b1;
            else
              state <= S_READ;
          end
        end
        S_READ: begin
          item    <= item + 16'd1;
          net_ptr <= net_ptr + 12'd1;
          // stays on the last input during the bias item
          if (item + 16'd1 < total_in)
            in_ptr <= in_ptr + 12'd1;
          if (item == last_item) begin
            drain_cnt <= 1'b0;
            state     <= S_DRAIN;
          end
        end
        S_DRAIN: begin
          // two cycles of memory and rounder latency
          drain_cnt <= 1'b1;
          if (drain_cnt)
            state <= S_WRITE;
        end
        S_WRITE: begin
          // skip the unread bias slot
          if (!bias_en)
            net_ptr <= net_ptr + 12'd1;
          neuron <= neuron + 16'd1;
          item   <= '0;
          in_ptr <= in_offset;
          if (neuron == total_out - 16'd1) begin
            done  <= 1'b1;
            state <= S_IDLE;
          end else begin
            state <= S_READ;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // host must not request a job before the previous ack
  assert property (@(posedge clk) disable iff (!xrst) start |-> state == S_IDLE)
    else $error("gobou_ctrl: start while a job is running");

endmodule

/* source/gobou_mac.sv */
`timescale 1ns/1ps

module gobou_mac (
  input  logic              clk,
  input  logic              xrst,
  input  logic              acc_en,
  input  logic              acc_first,
  input  logic              acc_bias,
  input  gobou_pkg::data_t  img_rdata,
  input  gobou_pkg::data_t  net_rdata,
  input  gobou_pkg::qbits_t qbits,
  input  logic              relu_en,
  output gobou_pkg::data_t  result
);
  import gobou_pkg::*;

  logic  en_d;
  logic  first_d;
  logic  bias_d;
  logic  upd;
  acc_t  prod;
  acc_t  bias_term;
  acc_t  term;
  acc_t  acc;
  data_t shifted;
  data_t rounded;

  // align controls with memory read data
  always_ff @(posedge clk) begin
    if (!xrst) begin
      en_d    <= 1'b0;
      first_d <= 1'b0;
      bias_d  <= 1'b0;
      upd     <= 1'b0;
    end else begin
      en_d    <= acc_en;
      first_d <= acc_first;
      bias_d  <= acc_bias;
      upd     <= en_d;
    end
  end

  // ====================
  // accumulate
  // ====================
  assign prod      = acc_t'(img_rdata) * acc_t'(net_rdata);
  // bias is stored at output scale
  assign bias_term = acc_t'(net_rdata) <<< qbits;
  assign term      = bias_d ? bias_term : prod;

  always_ff @(posedge clk) begin
    if (en_d)
      acc <= first_d ? term : acc + term;
  end

  // ====================
  // rounder and relu
  // ====================
  assign shifted = data_t'(acc >>> qbits);
  // negative sums step down by one
  assign rounded = acc[$bits(acc_t)-1] ? shifted - 16'sd1 : shifted;

  // holds until the next neuron accumulates
  always_ff @(posedge clk) begin
    if (upd)
      result <= (relu_en && rounded[$bits(data_t)-1]) ? '0 : rounded;
  end

endmodule

/* source/kinpira_top.sv */
`timescale 1ns/1ps

module kinpira_top #(
  parameter int IMG_DEPTH = 4096,
  parameter int NET_DEPTH = 4096
) (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  reg_we,
  input  logic                  reg_re,
  input  ninjin_pkg::reg_addr_t reg_addr,
  input  ninjin_pkg::word_t     reg_wdata,
  output ninjin_pkg::word_t     reg_rdata,
  output logic                  reg_rvalid,
  input  logic                  net_we,
  input  gobou_pkg::net_addr_t  net_addr,
  input  gobou_pkg::data_t      net_wdata,
  input  logic                  img_we,
  input  logic                  img_re,
  input  gobou_pkg::img_addr_t  img_addr,
  input  gobou_pkg::data_t      img_wdata,
  output gobou_pkg::data_t      img_rdata,
  output logic                  img_rvalid,
  output logic                  ack
);
  import gobou_pkg::*;

  logic      start;
  logic      done;
  logic      busy;
  qbits_t    qbits;
  img_addr_t in_offset;
  img_addr_t out_offset;
  net_addr_t net_offset;
  count_t    total_out;
  count_t    total_in;
  logic      bias_en;
  logic      relu_en;
  img_addr_t eng_addr;
  logic      eng_we;
  net_addr_t net_raddr;
  data_t     net_rdata;
  logic      acc_en;
  logic      acc_first;
  logic      acc_bias;
  data_t     result;

  // ====================
  // control plane
  // ====================
  ninjin_regs ninjin_regs_inst (
    .clk        (clk),
    .xrst       (xrst),
    .reg_we     (reg_we),
    .reg_re     (reg_re),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .done       (done),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .start      (start),
    .ack        (ack),
    .qbits      (qbits),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_out  (total_out),
    .total_in   (total_in),
    .bias_en    (bias_en),
    .relu_en    (relu_en)
  );

  // ====================
  // memories
  // ====================
  // read data is shared by host and engine
  image_buffer #(
    .IMG_DEPTH (IMG_DEPTH)
  ) image_buffer_inst (
    .clk         (clk),
    .xrst        (xrst),
    .host_we     (img_we),
    .host_re     (img_re),
    .host_addr   (img_addr),
    .host_wdata  (img_wdata),
    .eng_own     (busy),
    .eng_we      (eng_we),
    .eng_addr    (eng_addr),
    .eng_wdata   (result),
    .rdata       (img_rdata),
    .host_rvalid (img_rvalid)
  );

  weight_buffer #(
    .NET_DEPTH (NET_DEPTH)
  ) weight_buffer_inst (
    .clk       (clk),
    .net_we    (net_we),
    .net_addr  (net_addr),
    .net_wdata (net_wdata),
    .raddr     (net_raddr),
    .rdata     (net_rdata)
  );

  // ====================
  // engine
  // ====================
  gobou_ctrl gobou_ctrl_inst (
    .clk        (clk),
    .xrst       (xrst),
    .start      (start),
    .in_offset  (in_offset),
    .out_offset (out_offset),
    .net_offset (net_offset),
    .total_out  (total_out),
    .total_in   (total_in),
    .bias_en    (bias_en),
    .busy       (busy),
    .done       (done),
    .eng_addr   (eng_addr),
    .eng_we     (eng_we),
    .net_raddr  (net_raddr),
    .acc_en     (acc_en),
    .acc_first  (acc_first),
    .acc_bias   (acc_bias)
  );

  gobou_mac gobou_mac_inst (
    .clk       (clk),
    .xrst      (xrst),
    .acc_en    (acc_en),
    .acc_first (acc_first),
    .acc_bias  (acc_bias),
    .img_rdata (img_rdata),
    .net_rdata (net_rdata),
    .qbits     (qbits),
    .relu_en   (relu_en),
    .result    (result)
  );

endmodule

/* verif/kinpira_tb.sv */
`timescale 1ns/1ps

module kinpira_tb;
  import ninjin_pkg::*;
  import gobou_pkg::*;

  localparam int RAND_ANY = 0;
  localparam int RAND_POS = 1;
  localparam int RAND_NEG = 2;

  // slack plus twice total_out * (total_in + 4) for every job
  localparam int WATCHDOG_CYCLES = 2000 + 2 * (4 * (8 + 4) + 4 * (8 + 4) + 2 * 4 * (8 + 4)
                                               + 5 * (6 + 4) + 3 * (4 + 4));

  logic      clk;
  logic      xrst;
  logic      reg_we;
  logic      reg_re;
  reg_addr_t reg_addr;
  word_t     reg_wdata;
  word_t     reg_rdata;
  logic      reg_rvalid;
  logic      net_we;
  net_addr_t net_addr;
  data_t     net_wdata;
  logic      img_we;
  logic      img_re;
  img_addr_t img_addr;
  data_t     img_wdata;
  data_t     img_rdata;
  logic      img_rvalid;
  logic      ack;

  int seed = 32'haef5;
  int err_count = 0;
  int fail_count = 0;

  // host side copies of both memories
  data_t img_model [4096];
  data_t net_model [4096];

  // expected read responses, in issue order
  word_t reg_exp_q [$];
  string reg_name_q [$];
  data_t img_exp_q [$];
  string img_name_q [$];
  bit    img_nonneg_q [$];

  kinpira_top kinpira_top_inst (
    .clk        (clk),
    .xrst       (xrst),
    .reg_we     (reg_we),
    .reg_re     (reg_re),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .net_we     (net_we),
    .net_addr   (net_addr),
    .net_wdata  (net_wdata),
    .img_we     (img_we),
    .img_re     (img_re),
    .img_addr   (img_addr),
    .img_wdata  (img_wdata),
    .img_rdata  (img_rdata),
    .img_rvalid (img_rvalid),
    .ack        (ack)
  );

  always #2 clk = ~clk;

  // ====================
  // reference model
  // ====================
  function automatic data_t fc_ref(int o, int q, int in_off, int net_off, int tin,
                                   bit bias, bit relu);
    longint sum;
    int     base;
    data_t  r;
    base = net_off + o * (tin + 1);
    sum = 0;
    for (int i = 0; i < tin; i++)
      sum += longint'(img_model[img_addr_t'(in_off + i)])
             * longint'(net_model[net_addr_t'(base + i)]);
    if (bias)
      sum += longint'(net_model[net_addr_t'(base + tin)]) <<< q;
    r = data_t'(sum >>> q);
    if (sum < 0)
      r = r - 16'sd1;
    if (relu && r[$bits(data_t)-1])
      r = '0;
    return r;
  endfunction

  function automatic data_t rand_data(int mode);
    int v;
    v = $random(seed) % 2048;
    if (mode == RAND_POS)
      v = ((v < 0) ? -v : v) + 1;
    else if (mode == RAND_NEG)
      v = ((v < 0) ? v : -v) - 1;
    return data_t'(v);
  endfunction

  // ====================
  // compare tasks
  // ====================
  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      err_count++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_data(string name, data_t exp, data_t act);
    if (act !== exp) begin
      err_count++;
      $display("error %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  always @(negedge clk) begin : compare_reads
    bit nonneg;
    if (reg_rvalid) begin
      if (reg_exp_q.size() == 0) begin
        fail_count++;
        $display("register read data arrived with no read pending");
      end else begin
        check_word(reg_name_q.pop_front(), reg_exp_q.pop_front(), reg_rdata);
      end
    end
    if (img_rvalid) begin
      if (img_exp_q.size() == 0) begin
        fail_count++;
        $display("image read data arrived with no read pending");
      end else begin
        nonneg = img_nonneg_q.pop_front();
        if (nonneg && img_rdata[$bits(data_t)-1]) begin
          fail_count++;
          $display("%s is negative although relu is on", img_name_q[0]);
        end
        check_data(img_name_q.pop_front(), img_exp_q.pop_front(), img_rdata);
      end
    end
  end

  // ====================
  // host port tasks
  // ====================
  task automatic reg_write(reg_addr_t a, word_t d);
    @(posedge clk);
    reg_we    <= 1'b1;
    reg_addr  <= a;
    reg_wdata <= d;
    @(posedge clk);
    reg_we <= 1'b0;
  endtask

  task automatic reg_read(reg_addr_t a, word_t exp, string name);
    @(posedge clk);
    reg_re   <= 1'b1;
    reg_addr <= a;
    reg_exp_q.push_back(exp);
    reg_name_q.push_back(name);
    @(posedge clk);
    reg_re <= 1'b0;
    @(negedge clk);
    if (!reg_rvalid) begin
      fail_count++;
      $display("%s: register read data did not arrive one cycle after the read", name);
    end
  endtask

  task automatic img_write(img_addr_t a, data_t d);
    @(posedge clk);
    img_we    <= 1'b1;
    img_addr  <= a;
    img_wdata <= d;
    img_model[a] = d;
    @(posedge clk);
    img_we <= 1'b0;
  endtask

  task automatic img_read(img_addr_t a, string name, bit nonneg);
    @(posedge clk);
    img_re   <= 1'b1;
    img_addr <= a;
    img_exp_q.push_back(img_model[a]);
    img_name_q.push_back(name);
    img_nonneg_q.push_back(nonneg);
    @(posedge clk);
    img_re <= 1'b0;
    @(negedge clk);
    if (!img_rvalid) begin
      fail_count++;
      $display("%s: image read data did not arrive one cycle after the read", name);
    end
  endtask

  task automatic net_write(net_addr_t a, data_t d);
    @(posedge clk);
    net_we    <= 1'b1;
    net_addr  <= a;
    net_wdata <= d;
    net_model[a] = d;
    @(posedge clk);
    net_we <= 1'b0;
  endtask

  task automatic load_inputs(int off, int n, int mode);
    for (int i = 0; i < n; i++)
      img_write(img_addr_t'(off + i), rand_data(mode));
  endtask

  // weights plus one bias slot per neuron
  task automatic load_weights(int off, int tin, int tout, int mode);
    for (int k = 0; k < tout * (tin + 1); k++)
      net_write(net_addr_t'(off + k), rand_data(mode));
  endtask

  task automatic start_and_wait(string name, word_t req);
    bit was_high;
    bit fell;
    was_high = ack;
    fell     = 1'b0;
    reg_write(REG_REQ, req);
    repeat (4) begin
      @(negedge clk);
      if (!ack)
        fell = 1'b1;
    end
    // ack is still low before the first job
    if (was_high && !fell) begin
      fail_count++;
      $display("%s: ack did not fall after the job request", name);
    end
    while (!ack)
      @(negedge clk);
  endtask

  // ====================
  // tests
  // ====================
  task automatic test_registers();
    reg_addr_t mapped [7];
    word_t     wr [7];
    word_t     req_word;
    mapped = '{REG_QBITS, REG_IN_OFFSET, REG_OUT_OFFSET, REG_NET_OFFSET,
               REG_BASE, REG_BIAS, REG_ACTV};
    reg_read(REG_STATUS, 32'd0, "status_after_reset");
    for (int k = 0; k < 7; k++) begin
      wr[k] = $random(seed);
      reg_write(mapped[k], wr[k]);
    end
    for (int k = 0; k < 7; k++)
      reg_read(mapped[k], wr[k], $sformatf("readback_%0d", mapped[k]));
    // zero outputs, so the request finishes at once
    reg_write(REG_BASE, 32'd0);
    reg_read(REG_BASE, 32'd0, "readback_base_zero");
    req_word = $random(seed);
    start_and_wait("empty_job", req_word);
    reg_read(REG_REQ, req_word, "readback_req");
    reg_read(REG_STATUS, 32'd1, "status_after_job");
    reg_read(6'd0, 32'd0, "unmapped_0");
    reg_read(6'd6, 32'd0, "unmapped_6");
    reg_read(6'd11, 32'd0, "unmapped_11");
    reg_read(6'd61, 32'd0, "unmapped_61");
    reg_read(6'd63, 32'd0, "unmapped_63");
  endtask

  task automatic run_job(string name, int q, int in_off, int out_off, int net_off,
                         int tin, int tout, bit bias, bit relu);
    data_t exp_q [$];
    reg_write(REG_QBITS, word_t'(q));
    reg_write(REG_IN_OFFSET, word_t'(in_off));
    reg_write(REG_OUT_OFFSET, word_t'(out_off));
    reg_write(REG_NET_OFFSET, word_t'(net_off));
    reg_write(REG_BASE, {count_t'(tout), count_t'(tin)});
    reg_write(REG_BIAS, {bias, 31'd0});
    reg_write(REG_ACTV, {relu, 31'd0});
    for (int o = 0; o < tout; o++)
      exp_q.push_back(fc_ref(o, q, in_off, net_off, tin, bias, relu));
    start_and_wait(name, 32'd1);
    for (int o = 0; o < tout; o++) begin
      img_model[img_addr_t'(out_off + o)] = exp_q[o];
      img_read(img_addr_t'(out_off + o), $sformatf("%s[%0d]", name, o), relu);
    end
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    clk       = 1'b0;
    xrst      = 1'b0;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    net_we    = 1'b0;
    net_addr  = '0;
    net_wdata = '0;
    img_we    = 1'b0;
    img_re    = 1'b0;
    img_addr  = '0;
    img_wdata = '0;
    repeat (16) @(posedge clk);
    xrst <= 1'b1;

    test_registers();

    load_inputs(12'h000, 8, RAND_ANY);
    load_weights(12'h000, 8, 4, RAND_ANY);
    run_job("plain", 6, 12'h000, 12'h100, 12'h000, 8, 4, 1'b0, 1'b0);

    load_inputs(12'h010, 8, RAND_ANY);
    load_weights(12'h040, 8, 4, RAND_ANY);
    run_job("bias_relu", 6, 12'h010, 12'h110, 12'h040, 8, 4, 1'b1, 1'b1);

    // positive inputs against negative weights
    load_inputs(12'h020, 8, RAND_POS);
    load_weights(12'h080, 8, 4, RAND_NEG);
    run_job("neg_q0", 0, 12'h020, 12'h120, 12'h080, 8, 4, 1'b0, 1'b0);
    run_job("neg_q15", 15, 12'h020, 12'h128, 12'h080, 8, 4, 1'b0, 1'b0);

    // second job overwrites the upper part of the first output range
    load_inputs(12'h030, 6, RAND_ANY);
    load_weights(12'h0c0, 6, 5, RAND_ANY);
    load_inputs(12'h040, 4, RAND_ANY);
    load_weights(12'h100, 4, 3, RAND_ANY);
    run_job("chain_first", 4, 12'h030, 12'h300, 12'h0c0, 6, 5, 1'b1, 1'b0);
    run_job("chain_second", 8, 12'h040, 12'h303, 12'h100, 4, 3, 1'b0, 1'b1);
    for (int o = 0; o < 3; o++)
      img_read(img_addr_t'(12'h300 + o), $sformatf("chain_keep[%0d]", o), 1'b0);

    repeat (4) @(negedge clk);
    if (reg_exp_q.size() != 0 || img_exp_q.size() != 0) begin
      fail_count++;
      $display("%0d register and %0d image reads got no response",
               reg_exp_q.size(), img_exp_q.size());
    end
    $display("errors: %0d value mismatches, %0d other failures", err_count, fail_count);
    if (err_count == 0 && fail_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("run timed out waiting for ack after %0d cycles", WATCHDOG_CYCLES);
    $display("errors: %0d value mismatches, %0d other failures", err_count, fail_count + 1);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* vlog.f */
source/ninjin_pkg.sv
source/gobou_pkg.sv
source/ninjin_regs.sv
source/image_buffer.sv
source/weight_buffer.sv
source/gobou_ctrl.sv
source/gobou_mac.sv
source/kinpira_top.sv
verif/kinpira_tb.sv

/* run.sh */
#!/bin/sh
# build and run the kinpira testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module kinpira_tb -o kinpira_sim; then
  echo "verilator compile failed"
  exit 1
fi

out=$(./obj_dir/kinpira_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -Fqx '>>> PASS'; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
